// ==== hw/mem_hier_params.svh ====
// Widths and timing constants for the memory hierarchy
// Address split, cache geometry and SRAM access length

`ifndef MEM_HIER_PARAMS_SVH
`define MEM_HIER_PARAMS_SVH

////////////////////////////////////////
// CPU side
`define MH_ADDR_W 32 // Byte address
`define MH_DATA_W 32 // One cache line holds one word
`define MH_OFFSET_W 2 // Byte offset inside a word

////////////////////////////////////////
// Cache geometry
`define MH_INDEX_W 11 // 2048 lines
`define MH_TAG_W 19 // Address bits above index and offset

////////////////////////////////////////
// External pseudo-SRAM
`define MH_SRAM_ADDR_W 23 // Halfword address
`define MH_SRAM_WAIT 3 // Cycles per halfword access

`endif

// ==== hw/mem_hier_pkg.sv ====
// Shared types of the memory hierarchy
// Controller states, SRAM phases, tag entries, request and response

`default_nettype none

`include "mem_hier_params.svh"

package mem_hier_pkg;

	// Bit 0 data port, bit 1 instruction port, bit 2 write
	typedef enum logic [2:0] {
		cs_idle           = 3'b000, // Hits or nothing requested
		cs_d_miss         = 3'b001, // Data fill
		cs_i_miss         = 3'b010, // Instruction fill
		cs_id_miss        = 3'b011, // Both fills
		cs_d_write        = 3'b101, // Write-through
		cs_d_write_i_miss = 3'b111 // Instruction fill, then write-through
	} cache_state_e;

	typedef enum logic [2:0] {
		sp_idle, // Waiting for a request
		sp_lo,   // Low halfword on the bus
		sp_hi,   // High halfword on the bus
		sp_done  // Request drops, one turnaround cycle
	} sram_phase_e;

	typedef struct packed {
		logic                 valid;
		logic [`MH_TAG_W-1:0] tag;
	} tag_entry_t;

	// Cache controller to SRAM controller
	typedef struct packed {
		logic                  i_en;    // Instruction word fill
		logic                  d_en;    // Data word fill or write
		logic                  d_write; // Data job is a write
		logic [`MH_ADDR_W-1:0] i_addr;  // Word aligned
		logic [`MH_ADDR_W-1:0] d_addr;  // Word aligned
		logic [`MH_DATA_W-1:0] d_wdata;
	} mem_req_t;

	// SRAM controller back to the cache controller
	typedef struct packed {
		logic                  ready; // One cycle, all jobs done
		logic [`MH_DATA_W-1:0] i_rdata;
		logic [`MH_DATA_W-1:0] d_rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// ==== hw/cache_dual_ram.sv ====
// Dual-port RAM for the cache tag and data arrays
// Both ports act on the falling clock edge

`default_nettype none

module cache_dual_ram #(
	parameter int unsigned addr_w = 11,
	parameter int unsigned data_w = 32
) (
	input  wire logic              clk,
	input  wire logic              we_a,
	input  wire logic [addr_w-1:0] addr_a,
	input  wire logic [data_w-1:0] wdata_a,
	output logic      [data_w-1:0] rdata_a,
	input  wire logic              we_b,
	input  wire logic [addr_w-1:0] addr_b,
	input  wire logic [data_w-1:0] wdata_b,
	output logic      [data_w-1:0] rdata_b
);

	localparam int unsigned depth = 1 << addr_w;

	// Starts cleared so every valid bit is low
	logic [data_w-1:0] mem [depth] = '{default: '0};

	// Half a cycle after the address arrives the word is out,
	// which gives the controller a same-cycle hit
	always_ff @(negedge clk) begin
		if (we_a)
			mem[addr_a] <= wdata_a;
		if (we_b)
			mem[addr_b] <= wdata_b; // Port b wins on a shared index
		rdata_a <= mem[addr_a]; // Old contents
		rdata_b <= mem[addr_b];
	end

	// Same line written by both ports must agree
	assert property (@(negedge clk)
		!(we_a && we_b && (addr_a == addr_b) && (wdata_a != wdata_b)))
		else $error("cache_dual_ram: conflicting writes to index %0h", addr_a);

endmodule

`default_nettype wire

// ==== hw/cache_ctrl.sv ====
// Cache controller for the unified direct-mapped cache
// Hit detection, miss and write FSM, array writes, CPU stall
// Write-through with write-allocate

`default_nettype none

`include "mem_hier_params.svh"

module cache_ctrl (
	input  wire logic                        clk,
	input  wire logic                        rst,
	input  wire logic                        ie,
	input  wire logic                        de,
	input  wire logic                        drw,
	input  wire logic [`MH_ADDR_W-1:0]       iaddr,
	input  wire logic [`MH_ADDR_W-1:0]       daddr,
	input  wire logic [`MH_DATA_W-1:0]       din,
	input  wire mem_hier_pkg::tag_entry_t    i_tag_rd,
	input  wire mem_hier_pkg::tag_entry_t    d_tag_rd,
	input  wire mem_hier_pkg::mem_rsp_t      rsp,
	output logic                             cpu_stall,
	output mem_hier_pkg::mem_req_t           req,
	output logic      [`MH_INDEX_W-1:0]      i_index,
	output logic      [`MH_INDEX_W-1:0]      d_index,
	output logic                             i_we,
	output logic                             d_we,
	output mem_hier_pkg::tag_entry_t         i_tag_wr,
	output mem_hier_pkg::tag_entry_t         d_tag_wr,
	output logic      [`MH_DATA_W-1:0]       i_data_wr,
	output logic      [`MH_DATA_W-1:0]       d_data_wr
);

	import mem_hier_pkg::*;

	// Longest group is two words of two halfwords plus overhead
	localparam int unsigned busy_max = 4 * `MH_SRAM_WAIT + 4;

	cache_state_e state;
	cache_state_e state_nxt;

	logic [`MH_TAG_W-1:0] i_tag;
	logic [`MH_TAG_W-1:0] d_tag;
	logic i_hit;
	logic d_hit;
	logic i_miss;
	logic d_miss;
	logic d_wr;      // Write still to be sent through
	logic wr_done;   // Write finished in the previous cycle
	logic i_sel;     // State serves the instruction port
	logic d_sel;     // State serves the data port
	logic wr_sel;    // Data job is a write
	logic same_word; // Both ports on one word
	logic [7:0] busy_cycles;

	////////////////////////////////////////
	// Address split and hit detection

	assign i_tag   = iaddr[`MH_ADDR_W-1 -: `MH_TAG_W];
	assign d_tag   = daddr[`MH_ADDR_W-1 -: `MH_TAG_W];
	assign i_index = iaddr[`MH_OFFSET_W +: `MH_INDEX_W];
	assign d_index = daddr[`MH_OFFSET_W +: `MH_INDEX_W];

	// Tags come from the falling edge of this cycle
	assign i_hit = i_tag_rd.valid && (i_tag_rd.tag == i_tag);
	assign d_hit = d_tag_rd.valid && (d_tag_rd.tag == d_tag);

	assign i_miss = ie && !i_hit;
	assign d_miss = de && !drw && !d_hit;
	assign d_wr   = de && drw && !wr_done; // Every write goes to the SRAM once

	assign same_word = (iaddr[`MH_ADDR_W-1:`MH_OFFSET_W] == daddr[`MH_ADDR_W-1:`MH_OFFSET_W]);

	////////////////////////////////////////
	// FSM

	always_comb begin
		state_nxt = state;
		case (state)
			cs_idle: begin
				if (i_miss && d_wr)
					state_nxt = cs_d_write_i_miss;
				else if (d_wr)
					state_nxt = cs_d_write; // Also with the instruction port idle
				else if (i_miss && d_miss)
					state_nxt = cs_id_miss;
				else if (i_miss)
					state_nxt = cs_i_miss;
				else if (d_miss)
					state_nxt = cs_d_miss; // Also without a fetch
			end
			default: begin
				if (rsp.ready)
					state_nxt = cs_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= cs_idle;
			wr_done <= 1'b0;
		end else begin
			state   <= state_nxt;
			wr_done <= wr_sel && rsp.ready;
		end
	end

	// Stall until the cycle after the group ends, when the arrays read the new line
	assign cpu_stall = (state != cs_idle) || (state_nxt != cs_idle);

	assign i_sel  = state[1];
	assign d_sel  = state[0];
	assign wr_sel = state[2];

	////////////////////////////////////////
	// SRAM request, held by the registered state

	always_comb begin
		req.i_en    = i_sel;
		req.d_en    = d_sel;
		req.d_write = wr_sel;
		req.i_addr  = {iaddr[`MH_ADDR_W-1:`MH_OFFSET_W], {`MH_OFFSET_W{1'b0}}};
		req.d_addr  = {daddr[`MH_ADDR_W-1:`MH_OFFSET_W], {`MH_OFFSET_W{1'b0}}};
		req.d_wdata = din;
	end

	////////////////////////////////////////
	// Array writes on ready

	assign i_we = i_sel && rsp.ready;
	assign d_we = d_sel && rsp.ready;

	assign i_tag_wr = '{valid: 1'b1, tag: i_tag};
	assign d_tag_wr = '{valid: 1'b1, tag: d_tag};

	// Fetch of the word being written sees the new value
	assign i_data_wr = (wr_sel && same_word) ? din : rsp.i_rdata;
	assign d_data_wr = wr_sel ? din : rsp.d_rdata; // Write-allocate

	// Two ports on one index with different tags
	// cannot share the line; the RAM check catches it

	////////////////////////////////////////
	// Checks

	always_ff @(posedge clk) begin
		if (rst || state == cs_idle)
			busy_cycles <= '0;
		else
			busy_cycles <= busy_cycles + 8'd1;
	end

	// SRAM controller finishes every group in time
	assert property (@(posedge clk) disable iff (rst)
		busy_cycles <= 8'(busy_max))
		else $error("cache_ctrl: stuck in state %s", state.name());

	// CPU released only after the SRAM side reports ready
	assert property (@(posedge clk) disable iff (rst)
		$fell(cpu_stall) |-> $past(rsp.ready))
		else $error("cache_ctrl: stall dropped before ready");

endmodule

`default_nettype wire

// ==== hw/sram_ctrl.sv ====
// Controller for the asynchronous 16-bit pseudo-SRAM
// Instruction fill first, then data fill or write-through
// Each word is two halfword accesses, low half first

`default_nettype none

`include "mem_hier_params.svh"

module sram_ctrl (
	input  wire logic                          clk,
	input  wire logic                          rst,
	input  wire mem_hier_pkg::mem_req_t        req,
	output mem_hier_pkg::mem_rsp_t             rsp,
	output logic                               sram_ce,
	output logic                               sram_oe,
	output logic                               sram_we,
	output logic                               sram_lb,
	output logic                               sram_ub,
	output logic      [`MH_SRAM_ADDR_W-1:0]    sram_addr,
	inout  wire       [`MH_DATA_W/2-1:0]       sram_data
);

	import mem_hier_pkg::*;

	localparam int unsigned half_w = `MH_DATA_W / 2;
	localparam int unsigned cnt_w  = $clog2(`MH_SRAM_WAIT + 1);
	localparam logic [cnt_w-1:0] cnt_last = cnt_w'(`MH_SRAM_WAIT - 1);

	sram_phase_e phase;
	logic [cnt_w-1:0] cnt;  // Cycles left on this halfword
	logic cur_d;            // Current job is the data word
	logic d_pend;           // Data job queued behind the fetch
	logic busy;
	logic cur_write;
	logic last_cycle;       // Final cycle of a halfword
	logic [`MH_ADDR_W-1:0] cur_addr;
	logic [half_w-1:0] lo_half;  // Low half of the word in flight
	logic [half_w-1:0] wr_half;
	logic [`MH_DATA_W-1:0] i_word; // Fetched word while the data job runs

	assign busy       = (phase == sp_lo) || (phase == sp_hi);
	assign last_cycle = (cnt == '0);
	assign cur_write  = cur_d && req.d_write;
	assign cur_addr   = cur_d ? req.d_addr : req.i_addr;

	////////////////////////////////////////
	// Sequencer

	always_ff @(posedge clk) begin
		if (rst) begin
			phase  <= sp_idle;
			cnt    <= '0;
			cur_d  <= 1'b0;
			d_pend <= 1'b0;
		end else begin
			case (phase)
				sp_idle: begin
					if (req.i_en || req.d_en) begin
						phase  <= sp_lo;
						cnt    <= cnt_last;
						cur_d  <= !req.i_en;             // Fetch goes first
						d_pend <= req.i_en && req.d_en;
					end
				end
				sp_lo: begin
					if (last_cycle) begin
						phase <= sp_hi;
						cnt   <= cnt_last;
					end else
						cnt <= cnt - 1'b1;
				end
				sp_hi: begin
					if (last_cycle) begin
						if (d_pend) begin // Straight on to the data word
							phase  <= sp_lo;
							cnt    <= cnt_last;
							cur_d  <= 1'b1;
							d_pend <= 1'b0;
						end else
							phase <= sp_done;
					end else
						cnt <= cnt - 1'b1;
				end
				sp_done: phase <= sp_idle; // Cache controller drops the request here
				default: phase <= sp_idle;
			endcase
		end
	end

	// Read halfwords, sampled at the end of each access
	always_ff @(posedge clk) begin
		if (phase == sp_lo && last_cycle)
			lo_half <= sram_data;
		if (phase == sp_hi && last_cycle && !cur_d)
			i_word <= {sram_data, lo_half};
	end

	////////////////////////////////////////
	// Response

	always_comb begin
		rsp.ready   = (phase == sp_hi) && last_cycle && !d_pend;
		rsp.i_rdata = cur_d ? i_word : {sram_data, lo_half}; // Live bus on a lone fetch
		rsp.d_rdata = {sram_data, lo_half};
	end

	////////////////////////////////////////
	// External bus

	assign sram_ce   = !busy;
	assign sram_oe   = !(busy && !cur_write);
	assign sram_we   = !(busy && cur_write);
	assign sram_lb   = !busy; // Whole halfwords only
	assign sram_ub   = !busy;
	assign sram_addr = {cur_addr[`MH_SRAM_ADDR_W:`MH_OFFSET_W], phase == sp_hi};

	assign wr_half   = (phase == sp_hi) ? req.d_wdata[`MH_DATA_W-1:half_w]
	                                    : req.d_wdata[half_w-1:0];
	assign sram_data = (busy && cur_write) ? wr_half : 'z; // Driven only while writing

	// Cache controller keeps the request steady while a group runs
	assert property (@(posedge clk) disable iff (rst)
		(busy && !rsp.ready) |=> $stable(req))
		else $error("sram_ctrl: request changed while busy");

endmodule

`default_nettype wire

// ==== hw/mem_hierarchy.sv ====
// Memory hierarchy top level
// Cache controller, tag and data arrays, pseudo-SRAM controller

`default_nettype none

`include "mem_hier_params.svh"

module mem_hierarchy (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       ie,
	input  wire logic                       de,
	input  wire logic                       drw,
	input  wire logic [`MH_ADDR_W-1:0]      iaddr,
	input  wire logic [`MH_ADDR_W-1:0]      daddr,
	input  wire logic [`MH_DATA_W-1:0]      din,
	output logic      [`MH_DATA_W-1:0]      iout,
	output logic      [`MH_DATA_W-1:0]      dout,
	output logic                            cpu_stall,
	output logic                            sram_ce,
	output logic                            sram_oe,
	output logic                            sram_we,
	output logic                            sram_lb,
	output logic                            sram_ub,
	output logic      [`MH_SRAM_ADDR_W-1:0] sram_addr,
	inout  wire       [`MH_DATA_W/2-1:0]    sram_data
);

	import mem_hier_pkg::*;

	mem_req_t mem_req;
	mem_rsp_t mem_rsp;

	tag_entry_t i_tag_rd;
	tag_entry_t d_tag_rd;
	tag_entry_t i_tag_wr;
	tag_entry_t d_tag_wr;

	logic [`MH_INDEX_W-1:0] i_index;
	logic [`MH_INDEX_W-1:0] d_index;
	logic i_we;
	logic d_we;
	logic [`MH_DATA_W-1:0] i_data_wr;
	logic [`MH_DATA_W-1:0] d_data_wr;

	cache_ctrl u_cache_ctrl (
		.clk       (clk),
		.rst       (rst),
		.ie        (ie),
		.de        (de),
		.drw       (drw),
		.iaddr     (iaddr),
		.daddr     (daddr),
		.din       (din),
		.i_tag_rd  (i_tag_rd),
		.d_tag_rd  (d_tag_rd),
		.rsp       (mem_rsp),
		.cpu_stall (cpu_stall),
		.req       (mem_req),
		.i_index   (i_index),
		.d_index   (d_index),
		.i_we      (i_we),
		.d_we      (d_we),
		.i_tag_wr  (i_tag_wr),
		.d_tag_wr  (d_tag_wr),
		.i_data_wr (i_data_wr),
		.d_data_wr (d_data_wr)
	);

	// Port a serves fetches, port b the data side
	cache_dual_ram #(.addr_w(`MH_INDEX_W), .data_w($bits(tag_entry_t))) u_tag_ram (
		.clk     (clk),
		.we_a    (i_we),
		.addr_a  (i_index),
		.wdata_a (i_tag_wr),
		.rdata_a (i_tag_rd),
		.we_b    (d_we),
		.addr_b  (d_index),
		.wdata_b (d_tag_wr),
		.rdata_b (d_tag_rd)
	);

	cache_dual_ram #(.addr_w(`MH_INDEX_W), .data_w(`MH_DATA_W)) u_data_ram (
		.clk     (clk),
		.we_a    (i_we),
		.addr_a  (i_index),
		.wdata_a (i_data_wr),
		.rdata_a (iout),
		.we_b    (d_we),
		.addr_b  (d_index),
		.wdata_b (d_data_wr),
		.rdata_b (dout)
	);

	sram_ctrl u_sram_ctrl (
		.clk       (clk),
		.rst       (rst),
		.req       (mem_req),
		.rsp       (mem_rsp),
		.sram_ce   (sram_ce),
		.sram_oe   (sram_oe),
		.sram_we   (sram_we),
		.sram_lb   (sram_lb),
		.sram_ub   (sram_ub),
		.sram_addr (sram_addr),
		.sram_data (sram_data)
	);

endmodule

`default_nettype wire

// ==== test/sram_model.sv ====
// Behavioral asynchronous 16-bit pseudo-SRAM
// Hash-preloaded contents, byte-lane writes, word peek

`default_nettype none

`include "mem_hier_params.svh"

module sram_model #(
	parameter int unsigned addr_w = 15 // 32K halfwords, 64 KB
) (
	input  wire logic                       ce,
	input  wire logic                       oe,
	input  wire logic                       we,
	input  wire logic                       lb,
	input  wire logic                       ub,
	input  wire logic [`MH_SRAM_ADDR_W-1:0] addr,
	inout  wire       [15:0]                data
);

	logic [15:0] mem [1 << addr_w];
	logic [addr_w-1:0] row;

	assign row  = addr[addr_w-1:0]; // Upper address bits alias
	assign data = (!ce && !oe && we) ? mem[row] : 'z;

	// Initial contents, a hash of the whole halfword address
	function automatic logic [15:0] init_half(input logic [addr_w-1:0] h);
		logic [31:0] x;
		x = 32'(h) * 32'h9e3779b1;
		return x[31:16] ^ 16'(h);
	endfunction

	// Word at a word-aligned byte address, low half first in memory
	function automatic logic [31:0] peek_word(input logic [31:0] byte_addr);
		logic [addr_w-1:0] lo_row;
		logic [addr_w-1:0] hi_row;
		lo_row = {byte_addr[addr_w:2], 1'b0};
		hi_row = {byte_addr[addr_w:2], 1'b1};
		return {mem[hi_row], mem[lo_row]};
	endfunction

	initial begin
		for (int h = 0; h < (1 << addr_w); h++)
			mem[h] = init_half(addr_w'(h));
		forever begin
			@(ce or we or lb or ub or addr or data);
			#1; // Address and data settle after the controller edge
			if (!ce && !we) begin
				if (!lb)
					mem[row][7:0] = data[7:0];
				if (!ub)
					mem[row][15:8] = data[15:8];
			end
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_mem_hierarchy.sv ====
// Testbench for the memory hierarchy
// Directed cache tests and a random mix checked against a shadow memory
// Compare process, cycle timeout, per-test report

`default_nettype none

`include "mem_hier_params.svh"

module tb_mem_hierarchy;

	localparam int unsigned n_directed  = 34;
	localparam int unsigned n_random    = 300;
	// Worst access is two words plus turnaround
	localparam int unsigned cycle_limit = (n_directed + n_random) * (4 * `MH_SRAM_WAIT + 4) + 50;

	logic clk = 1'b0;
	logic rst;
	logic ie;
	logic de;
	logic drw;
	logic [`MH_ADDR_W-1:0] iaddr;
	logic [`MH_ADDR_W-1:0] daddr;
	logic [`MH_DATA_W-1:0] din;
	logic [`MH_DATA_W-1:0] iout;
	logic [`MH_DATA_W-1:0] dout;
	logic cpu_stall;
	logic sram_ce;
	logic sram_oe;
	logic sram_we;
	logic sram_lb;
	logic sram_ub;
	logic [`MH_SRAM_ADDR_W-1:0] sram_addr;
	wire  [`MH_DATA_W/2-1:0] sram_data;

	// Expectations, handed to the compare process
	logic [`MH_DATA_W-1:0] exp_iout;
	logic [`MH_DATA_W-1:0] exp_dout;
	logic chk_i;
	logic chk_d;
	logic chk_wt;       // Write-through word in the SRAM
	logic exp_no_stall;
	int req_seq = 0;
	int done_seq = 0;
	int stall_cnt = 0;

	logic [`MH_DATA_W-1:0] shadow [16384]; // 64 KB of words
	logic [31:0] rng_state;
	string cur_test;
	int check_count = 0;
	int error_count = 0;
	int test_checks0;
	int test_errors0;
	int unsigned cycle_count = 0;

	mem_hierarchy u_mem_hierarchy (
		.clk(clk), .rst(rst), .ie(ie), .de(de), .drw(drw),
		.iaddr(iaddr), .daddr(daddr), .din(din),
		.iout(iout), .dout(dout), .cpu_stall(cpu_stall),
		.sram_ce(sram_ce), .sram_oe(sram_oe), .sram_we(sram_we),
		.sram_lb(sram_lb), .sram_ub(sram_ub),
		.sram_addr(sram_addr), .sram_data(sram_data)
	);

	sram_model u_sram (
		.ce(sram_ce), .oe(sram_oe), .we(sram_we), .lb(sram_lb), .ub(sram_ub),
		.addr(sram_addr), .data(sram_data)
	);

	always #50 clk = ~clk;

	////////////////////////////////////////
	// Reference model and random numbers

	// Halfword h of memory before any write
	function automatic logic [15:0] halfword_pattern(input logic [14:0] h);
		logic [31:0] x;
		x = 32'(h) * 32'h9e3779b1;
		return x[31:16] ^ 16'(h);
	endfunction

	function automatic logic [31:0] initial_word(input logic [13:0] w);
		return {halfword_pattern({w, 1'b1}), halfword_pattern({w, 1'b0})};
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] a);
		return shadow[a[15:2]];
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		rng_state = xorshift32(rng_state);
		return rng_state % n;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Few indexes and eight tags, so lines collide often
	function automatic logic [31:0] rand_addr();
		logic [10:0] idx;
		logic [2:0] tag;
		idx = 11'(rand_below(16) * 37);
		tag = 3'(rand_below(8));
		return {16'h0, tag, idx, 2'b00};
	endfunction

	////////////////////////////////////////
	// Checking

	task automatic check_value(input string what, input logic [31:0] expected,
	                           input logic [31:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("mismatch %s %s: expected %h actual %h", cur_test, what, expected, actual);
		end
	endtask

	// Outputs move on the falling edge and are stable at the rising one
	always @(posedge clk) begin
		if (!rst && req_seq != done_seq) begin
			if (cpu_stall)
				stall_cnt = stall_cnt + 1;
			else begin
				if (chk_i)
					check_value("iout", exp_iout, iout);
				if (chk_d)
					check_value("dout", exp_dout, dout);
				if (chk_wt)
					check_value("sram word", din, u_sram.peek_word(daddr));
				if (exp_no_stall)
					check_value("stall cycles", 32'd0, 32'(stall_cnt));
				stall_cnt = 0;
				done_seq = req_seq;
			end
		end
	end

	always @(posedge clk)
		cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= cycle_limit);
		$display("timeout: accesses still pending after %0d cycles", cycle_limit);
		$display("Regression failed");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus

	// One CPU access, held until the stall clears
	task automatic run_access(input logic i_on, input logic [31:0] ia, input logic d_on,
	                          input logic wr, input logic [31:0] da, input logic [31:0] wd,
	                          input logic no_stall);
		int seq;
		seq = req_seq + 1;
		if (d_on && wr)
			shadow[da[15:2]] = wd; // Applied before the fetch of the same word
		ie           <= i_on;
		iaddr        <= ia;
		de           <= d_on;
		drw          <= d_on && wr;
		daddr        <= da;
		din          <= wd;
		chk_i        <= i_on;
		chk_d        <= d_on;
		chk_wt       <= d_on && wr;
		exp_iout     <= expected_word(ia);
		exp_dout     <= expected_word(da);
		exp_no_stall <= no_stall;
		req_seq      <= seq;
		@(posedge clk);
		wait (done_seq == seq);
	endtask

	task automatic iread(input logic [31:0] a, input logic no_stall);
		run_access(1'b1, a, 1'b0, 1'b0, 32'h0, 32'h0, no_stall);
	endtask

	task automatic dread(input logic [31:0] a, input logic no_stall);
		run_access(1'b0, 32'h0, 1'b1, 1'b0, a, 32'h0, no_stall);
	endtask

	task automatic dwrite(input logic [31:0] a, input logic [31:0] wd);
		run_access(1'b0, 32'h0, 1'b1, 1'b1, a, wd, 1'b0);
	endtask

	task automatic begin_test(input string name);
		cur_test     = name;
		test_checks0 = check_count;
		test_errors0 = error_count;
	endtask

	task automatic end_test();
		$display("test %s: %0d checks, %0d errors", cur_test,
		         check_count - test_checks0, error_count - test_errors0);
	endtask

	task automatic reset_state();
		begin_test("reset_state");
		// Chip, output, write and byte enables all idle high
		check_value("bus strobes", 32'h1f,
		            {27'h0, sram_ce, sram_oe, sram_we, sram_lb, sram_ub});
		end_test();
	endtask

	task automatic cold_misses();
		begin_test("cold_misses");
		iread(32'h0100, 1'b0);
		dread(32'h2204, 1'b0);
		iread(32'h0408, 1'b0);
		dread(32'h080c, 1'b0);
		dread(32'h0c10, 1'b0);
		end_test();
	endtask

	task automatic cached_reads();
		begin_test("cached_reads");
		iread(32'h0100, 1'b1);
		dread(32'h2204, 1'b1);
		iread(32'h0408, 1'b1);
		dread(32'h080c, 1'b1);
		run_access(1'b1, 32'h0100, 1'b1, 1'b0, 32'h0c10, 32'h0, 1'b1);
		dread(32'h0408, 1'b1); // Line filled by a fetch
		iread(32'h2204, 1'b1);
		end_test();
	endtask

	task automatic write_readback();
		begin_test("write_readback");
		dwrite(32'h080c, 32'h1234_5678);
		dread(32'h080c, 1'b1);
		dwrite(32'h3000, 32'h0bad_f00d); // Allocates a cold line
		iread(32'h3000, 1'b1);
		dread(32'h3000, 1'b1);
		iread(32'h080c, 1'b1);
		end_test();
	endtask

	task automatic conflict_eviction();
		begin_test("conflict_eviction");
		dread(32'h0a40, 1'b0); // Same index, tags 0 and 1
		dread(32'h2a40, 1'b0);
		dread(32'h0a40, 1'b0);
		dread(32'h2a40, 1'b0);
		iread(32'h0a40, 1'b0);
		iread(32'h2a40, 1'b0);
		iread(32'h0a40, 1'b0);
		end_test();
	endtask

	task automatic dual_misses();
		begin_test("dual_misses");
		run_access(1'b1, 32'h1100, 1'b1, 1'b0, 32'h1504, 32'h0, 1'b0);
		run_access(1'b1, 32'h1908, 1'b1, 1'b1, 32'h1d0c, 32'h5555_aaaa, 1'b0);
		run_access(1'b1, 32'h4010, 1'b1, 1'b1, 32'h4010, 32'hdead_0042, 1'b0);
		dread(32'h1100, 1'b1);
		iread(32'h1504, 1'b1);
		dread(32'h1908, 1'b1);
		iread(32'h1d0c, 1'b1);
		dread(32'h4010, 1'b1);
		iread(32'h4010, 1'b1);
		end_test();
	endtask

	task automatic random_mix();
		int n;
		int kind;
		logic [31:0] ia;
		logic [31:0] da;
		logic [31:0] wd;
		begin_test("random_mix");
		for (n = 0; n < n_random; n++) begin
			kind = int'(rand_below(5));
			ia   = rand_addr();
			da   = rand_addr();
			wd   = rand_word();
			if (kind >= 3 && ia[12:2] == da[12:2])
				da = ia; // Both ports on one line need the same tag
			case (kind)
				0: iread(ia, 1'b0);
				1: dread(da, 1'b0);
				2: dwrite(da, wd);
				3: run_access(1'b1, ia, 1'b1, 1'b0, da, 32'h0, 1'b0);
				default: run_access(1'b1, ia, 1'b1, 1'b1, da, wd, 1'b0);
			endcase
		end
		end_test();
	endtask

	initial begin
		rst       = 1'b1;
		ie        = 1'b0;
		de        = 1'b0;
		drw       = 1'b0;
		iaddr     = '0;
		daddr     = '0;
		din       = '0;
		rng_state = 32'd19852;
		for (int w = 0; w < 16384; w++)
			shadow[w] = initial_word(14'(w));
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		reset_state();
		cold_misses();
		cached_reads();
		write_readback();
		conflict_eviction();
		dual_misses();
		random_mix();
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/mem_hier_pkg.sv
hw/cache_dual_ram.sv
hw/cache_ctrl.sv
hw/sram_ctrl.sv
hw/mem_hierarchy.sv
test/sram_model.sv
test/tb_mem_hierarchy.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the memory hierarchy testbench with Verilator

cd "$(dirname "$0")" || exit 1

obj=obj_dir
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_hierarchy -Mdir "$obj" -f filelist.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$obj/Vtb_mem_hierarchy" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Regression passed" "$log"; then
	exit 0
fi
echo "no pass line in $log"
exit 1
